/* hdl/cart_pkg.sv */
package cart_pkg;

    // ROM image geometry
    localparam int rom_addr_bits = 18;

    typedef logic [rom_addr_bits-1:0] rom_addr_t;   // Byte address into the image
    typedef logic [rom_addr_bits-2:0] word_addr_t;  // 16-bit word address
    typedef logic [14:0]              cpu_addr_t;   // CPU window at $8000-$FFFF
    typedef logic [15:0]              rom_word_t;
    typedef logic [7:0]               rom_byte_t;

    // SDRAM timing in clk cycles
    localparam int sdram_read_latency = 6;
    localparam int refresh_cycles     = 8;
    localparam int refresh_interval   = 200;  // Forced refresh after this many cycles

    typedef enum logic [1:0] {
        read_start,
        read_end,
        wait_release
    } prg_state_t;

    typedef enum logic [1:0] {
        idle,
        access,
        refreshing
    } ctrl_state_t;

endpackage

/* hdl/cpu_bus_sync.sv */
`timescale 1ns/1ns

module cpu_bus_sync (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                m2,
    input  logic                cpu_rw,
    input  logic                rom_ce,
    input  cart_pkg::cpu_addr_t addr,
    input  cart_pkg::rom_addr_t offset,
    output logic                read_active,
    output cart_pkg::rom_addr_t byte_addr
);
    logic                read_cond;
    logic                read_q;
    logic [1:0]          read_sync;
    cart_pkg::rom_addr_t merged_addr;
    cart_pkg::rom_addr_t addr_q;
    cart_pkg::rom_addr_t addr_q2;

    // ROM read cycle on the cartridge bus
    assign read_cond = !rom_ce && cpu_rw && m2;

    // Bank base is ORed onto the zero extended CPU address
    assign merged_addr = cart_pkg::rom_addr_t'(addr) | offset;

    assign read_active = read_sync[1];

    // Input register, then two-flop synchronizer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_q    <= 1'b0;
            read_sync <= 2'b00;
        end else begin
            read_q    <= read_cond;
            read_sync <= {read_sync[0], read_q};
        end
    end

    // Address runs through the same depth so it lines up with read_active.
    // The bus holds it stable for the whole m2 high phase, so a wrong early
    // sample is flushed long before the strobe arrives
    always_ff @(posedge clk) begin
        addr_q    <= merged_addr;
        addr_q2   <= addr_q;
        byte_addr <= addr_q2;
    end

endmodule

/* hdl/prg_rom.sv */
`timescale 1ns/1ns

module prg_rom (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 read_active,
    input  cart_pkg::rom_addr_t  byte_addr,
    output logic                 refresh,
    output cart_pkg::rom_byte_t  data,
    output logic                 ram_req,
    output cart_pkg::word_addr_t ram_address,
    output logic                 ram_we,
    input  logic                 ram_ack,
    input  cart_pkg::rom_word_t  ram_data_read
);
    cart_pkg::prg_state_t state;
    cart_pkg::word_addr_t word_addr;
    cart_pkg::word_addr_t tag;
    cart_pkg::rom_word_t  cache_word;
    logic                 cache_valid;
    logic                 low_bit;
    logic                 hit;
    logic                 ram_idle;
    logic                 start;
    logic                 fill;

    assign word_addr = byte_addr[cart_pkg::rom_addr_bits-1:1];
    assign hit       = cache_valid && (tag == word_addr);
    assign ram_idle  = (ram_req == ram_ack);  // No request outstanding
    assign ram_we    = 1'b0;                  // ROM path only reads

    // A read may only begin once any old request has been answered
    assign start = enable && (state == cart_pkg::read_start) && read_active && ram_idle;
    assign fill  = enable && (state == cart_pkg::read_end) && ram_idle;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= cart_pkg::read_start;
            refresh     <= 1'b0;
            ram_req     <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            refresh <= 1'b0;
            if (!enable) begin
                // Image may be reloaded, drop the cached word
                state       <= cart_pkg::read_start;
                cache_valid <= 1'b0;
            end else begin
                case (state)
                    cart_pkg::read_start: begin
                        if (start) begin
                            if (hit) begin
                                refresh <= 1'b1;  // SDRAM is free this access
                                state   <= cart_pkg::wait_release;
                            end else begin
                                ram_req     <= ~ram_req;
                                cache_valid <= 1'b0;
                                state       <= cart_pkg::read_end;
                            end
                        end
                    end
                    cart_pkg::read_end: begin
                        if (fill) begin
                            cache_valid <= 1'b1;
                            state       <= cart_pkg::wait_release;
                        end
                    end
                    cart_pkg::wait_release: begin
                        if (!read_active)
                            state <= cart_pkg::read_start;
                    end
                    default: state <= cart_pkg::read_start;
                endcase
            end
        end
    end

    // Cache contents and byte select
    always_ff @(posedge clk) begin
        if (start) begin
            low_bit <= byte_addr[0];
            if (!hit) begin
                tag         <= word_addr;
                ram_address <= word_addr;
            end
        end
        if (fill)
            cache_word <= ram_data_read;
        data <= low_bit ? cache_word[15:8] : cache_word[7:0];  // Odd address is high byte
    end

endmodule

/* hdl/sdram_ctrl.sv */
`timescale 1ns/1ns

module sdram_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 ram_req,
    input  cart_pkg::word_addr_t ram_address,
    input  logic                 ram_we,
    output logic                 ram_ack,
    output cart_pkg::rom_word_t  ram_data_read,
    input  logic                 refresh_hint,
    input  logic                 load_valid,
    input  cart_pkg::word_addr_t load_addr,
    input  cart_pkg::rom_word_t  load_data
);
    typedef logic [$clog2(cart_pkg::refresh_cycles + 1)-1:0] wait_cnt_t;
    typedef logic [$clog2(cart_pkg::refresh_interval + 1)-1:0] timer_t;

    // Image storage, one entry per 16-bit word
    cart_pkg::rom_word_t mem [0:(1 << (cart_pkg::rom_addr_bits - 1)) - 1];

    cart_pkg::ctrl_state_t state;
    wait_cnt_t             wait_cnt;
    timer_t                since_refresh;
    logic                  req_pending;
    logic                  force_refresh;
    logic                  start_refresh;
    logic                  access_done;

    assign req_pending   = (ram_req != ram_ack);
    assign force_refresh = (since_refresh == timer_t'(cart_pkg::refresh_interval - 1));

    // Refresh wins over a pending request, which then waits it out
    assign start_refresh = (state == cart_pkg::idle) && (refresh_hint || force_refresh);

    assign access_done = (state == cart_pkg::access) && (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= cart_pkg::idle;
            wait_cnt <= '0;
            ram_ack  <= 1'b0;
        end else begin
            case (state)
                cart_pkg::idle: begin
                    if (start_refresh) begin
                        wait_cnt <= wait_cnt_t'(cart_pkg::refresh_cycles - 1);
                        state    <= cart_pkg::refreshing;
                    end else if (req_pending) begin
                        // Ack shows up sdram_read_latency cycles after this one
                        wait_cnt <= wait_cnt_t'(cart_pkg::sdram_read_latency - 2);
                        state    <= cart_pkg::access;
                    end
                end
                cart_pkg::access: begin
                    if (wait_cnt == '0) begin
                        ram_ack <= ram_req;
                        state   <= cart_pkg::idle;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                cart_pkg::refreshing: begin
                    if (wait_cnt == '0)
                        state <= cart_pkg::idle;
                    else
                        wait_cnt <= wait_cnt - 1'b1;
                end
                default: state <= cart_pkg::idle;
            endcase
        end
    end

    // Cycles since the last refresh, saturates until one can start
    always_ff @(posedge clk) begin
        if (!rst_n)
            since_refresh <= '0;
        else if (start_refresh)
            since_refresh <= '0;
        else if (!force_refresh)
            since_refresh <= since_refresh + 1'b1;
    end

    // Read data lands together with the ack toggle.
    // Writes carry no data on this port and are only acknowledged
    always_ff @(posedge clk) begin
        if (access_done && !ram_we)
            ram_data_read <= mem[ram_address];
    end

    // Image load port, only while the ROM path is off
    always_ff @(posedge clk) begin
        if (!enable && load_valid)
            mem[load_addr] <= load_data;
    end

endmodule

/* hdl/nes_cart_top.sv */
`timescale 1ns/1ns

module nes_cart_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 m2,
    input  logic                 cpu_rw,
    input  logic                 rom_ce,
    input  cart_pkg::cpu_addr_t  addr,
    input  cart_pkg::rom_addr_t  offset,
    input  logic                 load_valid,
    input  cart_pkg::word_addr_t load_addr,
    input  cart_pkg::rom_word_t  load_data,
    output cart_pkg::rom_byte_t  data,
    output logic                 refresh
);
    // Bus sync to ROM reader
    logic                 read_active;
    cart_pkg::rom_addr_t  byte_addr;

    // ROM reader to SDRAM controller
    logic                 ram_req;
    logic                 ram_ack;
    logic                 ram_we;
    cart_pkg::word_addr_t ram_address;
    cart_pkg::rom_word_t  ram_data_read;

    cpu_bus_sync cpu_bus_sync_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .m2          (m2),
        .cpu_rw      (cpu_rw),
        .rom_ce      (rom_ce),
        .addr        (addr),
        .offset      (offset),
        .read_active (read_active),
        .byte_addr   (byte_addr)
    );

    prg_rom prg_rom_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .read_active   (read_active),
        .byte_addr     (byte_addr),
        .refresh       (refresh),
        .data          (data),
        .ram_req       (ram_req),
        .ram_address   (ram_address),
        .ram_we        (ram_we),
        .ram_ack       (ram_ack),
        .ram_data_read (ram_data_read)
    );

    // Hit pulse doubles as the refresh slot hint
    sdram_ctrl sdram_ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .ram_req       (ram_req),
        .ram_address   (ram_address),
        .ram_we        (ram_we),
        .ram_ack       (ram_ack),
        .ram_data_read (ram_data_read),
        .refresh_hint  (refresh),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_data     (load_data)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

endmodule

/* sim/nes_cart_tb.sv */
`timescale 1ns/1ns

module nes_cart_tb;
    logic                 clk;
    logic                 rst_n;
    logic                 enable;
    logic                 m2;
    logic                 cpu_rw;
    logic                 rom_ce;
    cart_pkg::cpu_addr_t  addr;
    cart_pkg::rom_addr_t  offset;
    logic                 load_valid;
    cart_pkg::word_addr_t load_addr;
    cart_pkg::rom_word_t  load_data;
    cart_pkg::rom_byte_t  data;
    logic                 refresh;

    // Reference image and a model of the one-word cache
    cart_pkg::rom_word_t  image [0:(1 << (cart_pkg::rom_addr_bits - 1)) - 1];
    logic                 model_valid;
    cart_pkg::word_addr_t model_tag;
    cart_pkg::rom_byte_t  last_byte;

    int errors;
    int checks;
    int refresh_count;

    tb_clock tb_clock_inst (.clk(clk));

    nes_cart_top nes_cart_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .m2         (m2),
        .cpu_rw     (cpu_rw),
        .rom_ce     (rom_ce),
        .addr       (addr),
        .offset     (offset),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .data       (data),
        .refresh    (refresh)
    );

    always @(posedge clk) begin
        if (!rst_n)
            refresh_count <= 0;
        else if (refresh)
            refresh_count <= refresh_count + 1;
    end

    // Hint is a single cycle pulse
    hint_width: assert property (@(posedge clk) disable iff (!rst_n) refresh |=> !refresh)
        else begin
            errors++;
            $display("Refresh hint stayed high for more than one cycle at %0t ns", $time);
        end

    hint_disabled: assert property (@(posedge clk) disable iff (!rst_n) !enable |=> !refresh)
        else begin
            errors++;
            $display("Refresh hint pulsed while the ROM path was disabled at %0t ns", $time);
        end

    // Odd byte address picks the high byte of the word
    function automatic cart_pkg::rom_byte_t expected_byte(input cart_pkg::rom_addr_t ba);
        cart_pkg::rom_word_t w;
        w = image[ba >> 1];
        return ba[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(negedge clk);
    endtask

    // One CPU bus cycle, m2 low for 16 clk cycles then high for 32
    task automatic cpu_cycle(input cart_pkg::cpu_addr_t a, input logic rw, input logic ce,
                             output int pulses, output cart_pkg::rom_byte_t sampled);
        int start_count;
        m2     = 1'b0;
        addr   = a;
        cpu_rw = rw;
        rom_ce = ce;
        wait_cycles(16);
        start_count = refresh_count;
        m2 = 1'b1;
        wait_cycles(32);
        sampled = data;     // Taken at the m2 fall
        pulses  = refresh_count - start_count;
        m2      = 1'b0;
        cpu_rw  = 1'b1;
        rom_ce  = 1'b1;
    endtask

    task automatic read_and_compare(input cart_pkg::cpu_addr_t a);
        cart_pkg::rom_addr_t ba;
        cart_pkg::rom_byte_t exp;
        cart_pkg::rom_byte_t got;
        logic                hit_exp;
        int                  pulses;
        ba      = cart_pkg::rom_addr_t'(a) | offset;
        exp     = expected_byte(ba);
        hit_exp = model_valid && (model_tag == ba[cart_pkg::rom_addr_bits-1:1]);
        cpu_cycle(a, 1'b1, 1'b0, pulses, got);
        checks += 2;
        read_data: assert (got == exp) else begin
            errors++;
            $display("FAILED data: expected 0x%h, got 0x%h at byte address 0x%h", exp, got, ba);
        end
        read_hint: assert (pulses == (hit_exp ? 1 : 0)) else begin
            errors++;
            $display("FAILED refresh pulses: expected 0x%h, got 0x%h at byte address 0x%h",
                     hit_exp ? 1 : 0, pulses, ba);
        end
        model_valid = 1'b1;
        model_tag   = ba[cart_pkg::rom_addr_bits-1:1];
        last_byte   = exp;
    endtask

    // Bus cycles the ROM path must ignore
    task automatic non_read_cycle(input cart_pkg::cpu_addr_t a, input logic rw, input logic ce);
        cart_pkg::rom_byte_t got;
        int                  pulses;
        cpu_cycle(a, rw, ce, pulses, got);
        checks += 2;
        idle_hint: assert (pulses == 0) else begin
            errors++;
            $display("FAILED refresh pulses: expected 0x0, got 0x%h (cpu_rw %b, rom_ce %b)",
                     pulses, rw, ce);
        end
        idle_data: assert (got == last_byte) else begin
            errors++;
            $display("FAILED data: expected 0x%h, got 0x%h after an ignored bus cycle",
                     last_byte, got);
        end
    endtask

    // Whole image, one word per cycle, enable must already be low
    task automatic load_image(input logic must_differ);
        cart_pkg::rom_word_t w;
        for (int i = 0; i < $size(image); i++) begin
            w = cart_pkg::rom_word_t'($urandom());
            if (must_differ)
                w = image[i] ^ (w | 16'hf0f0);  // Both bytes change
            image[i]   = w;
            load_valid = 1'b1;
            load_addr  = cart_pkg::word_addr_t'(i);
            load_data  = w;
            @(negedge clk);
        end
        load_valid  = 1'b0;
        model_valid = 1'b0;
    endtask

    initial begin
        cart_pkg::cpu_addr_t a;
        int                  pick;
        void'($urandom(32'h385f_477a));
        rst_n       = 1'b0;
        enable      = 1'b0;
        m2          = 1'b0;
        cpu_rw      = 1'b1;
        rom_ce      = 1'b1;
        addr        = '0;
        offset      = '0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        errors      = 0;
        checks      = 0;
        model_valid = 1'b0;
        model_tag   = '0;
        last_byte   = '0;

        wait_cycles(10);
        rst_n = 1'b1;
        wait_cycles(2);
        checks++;
        reset_hint: assert (refresh == 1'b0) else begin
            errors++;
            $display("FAILED refresh: expected 0x0, got 0x%h after reset", refresh);
        end

        load_image(1'b0);
        enable = 1'b1;
        wait_cycles(4);

        // Miss, then both bytes of the cached word hit
        a = cart_pkg::cpu_addr_t'($urandom());
        read_and_compare(a);
        read_and_compare(a ^ 15'h1);
        read_and_compare(a);

        // Banked reads, then the same CPU address in another bank
        offset = cart_pkg::rom_addr_t'($urandom() | 32'h8000);
        a = cart_pkg::cpu_addr_t'($urandom());
        read_and_compare(a);
        read_and_compare(a ^ 15'h1);
        offset = offset ^ 18'h2_0000;
        read_and_compare(a);

        non_read_cycle(a, 1'b0, 1'b0);
        non_read_cycle(a ^ 15'h2, 1'b1, 1'b1);
        non_read_cycle(a, 1'b0, 1'b1);

        // Cached word must not survive a reload
        offset = '0;
        a = cart_pkg::cpu_addr_t'($urandom());
        read_and_compare(a);
        read_and_compare(a);
        enable = 1'b0;
        wait_cycles(4);
        load_image(1'b1);
        non_read_cycle(a, 1'b1, 1'b0);  // ROM read while the path is off
        wait_cycles(4);
        enable = 1'b1;
        wait_cycles(4);
        read_and_compare(a);

        for (int k = 0; k < 200; k++) begin
            pick = int'($urandom() % 10);
            if (pick == 0)
                wait_cycles(cart_pkg::refresh_interval + int'($urandom() % 100) + 1);
            if (pick == 1)
                offset = cart_pkg::rom_addr_t'($urandom());
            if (pick < 5)
                a = a ^ 15'h1;  // Other byte, usually a hit
            else
                a = cart_pkg::cpu_addr_t'($urandom());
            read_and_compare(a);
        end

        wait_cycles(4);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* nes_cart.f */
hdl/cart_pkg.sv
hdl/cpu_bus_sync.sv
hdl/prg_rom.sv
hdl/sdram_ctrl.sv
hdl/nes_cart_top.sv
sim/tb_clock.sv
sim/nes_cart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f nes_cart.f --top-module nes_cart_tb -o nes_cart_sim > build.log 2>&1 &&
    ./obj_dir/nes_cart_sim > sim.log 2>&1 ||
    { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" ||
    { echo "FAIL"; exit 1; }
